// File: hdl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Program counter after reset, first opcode is fetched here
`define RESET_PC 16'h0000

// Stack pointer after reset
`define RESET_SP 16'hFFFE

// Bytes of memory, low address bits decode into it
`define MEM_DEPTH 1024

// Longest instruction in machine cycles
`define MAX_CYCLES 3

`endif

// File: hdl/cpu_pkg.sv
package cpu_pkg;

  // Clock phases within one machine cycle
  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  // Register pair that goes onto the address bus
  typedef enum logic [1:0] {ADDR_PC, ADDR_SP, ADDR_HL, ADDR_NONE} addr_src_t;

  typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_t;

  // 8-bit register names
  typedef enum logic [2:0] {REG_A, REG_B, REG_H, REG_L, REG_IR, REG_NONE} reg_sel_t;

  typedef enum logic [2:0] {
    ALU_NOP, ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_INC
  } alu_op_t;

  typedef enum logic {IDU_NONE, IDU_INC} idu_op_t;  // Acts on the addr_src pair

  // Supported subset, SM83 encodings
  typedef enum logic [7:0] {
    OP_NOP      = 8'h00,
    OP_LD_B_N   = 8'h06,
    OP_LD_HL_NN = 8'h21,
    OP_LD_HLI_A = 8'h22,
    OP_INC_HL   = 8'h23,
    OP_LD_H_N   = 8'h26,
    OP_LD_L_N   = 8'h2E,
    OP_INC_A    = 8'h3C,
    OP_LD_A_N   = 8'h3E,
    OP_HALT     = 8'h76,
    OP_LD_HL_A  = 8'h77,
    OP_LD_A_HL  = 8'h7E,
    OP_ADD_A_B  = 8'h80,
    OP_SUB_A_B  = 8'h90,
    OP_AND_A_B  = 8'hA0,
    OP_XOR_A_B  = 8'hA8,
    OP_OR_A_B   = 8'hB0
  } opcode_t;

  // One machine cycle of work
  typedef struct packed {
    addr_src_t addr_src;
    bus_op_t   bus_op;
    reg_sel_t  load_dst;   // Takes the byte read in T3
    reg_sel_t  store_src;  // Driven onto the bus for a write
    alu_op_t   alu_op;
    reg_sel_t  alu_dst;
    idu_op_t   idu_op;
    logic      halt;
  } micro_step_t;

  typedef struct packed {
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [7:0]  ir;
    logic [15:0] pc;
    logic [15:0] sp;
  } cpu_regs_t;

endpackage

// File: hdl/micro_if.sv
`timescale 1ns/10ps

interface micro_if import cpu_pkg::*; ();

  micro_step_t step;        // Current micro-step
  logic        load_en;     // T3 of a read
  logic [7:0]  load_byte;
  logic        commit;      // T4 strobe
  logic [7:0]  alu_result;
  logic [15:0] next_pair;   // Selected pair after the IDU

  modport seq (
    output step, load_en, load_byte, commit
  );

  // ALU and address unit each drive one result
  modport exec (
    input  step,
    output alu_result, next_pair
  );

  modport wb (
    input step, load_en, load_byte, commit, alu_result, next_pair
  );

endinterface

// File: hdl/control_rom.sv
`timescale 1ns/10ps

module control_rom import cpu_pkg::*; (
  input  opcode_t     opcode,
  input  logic [1:0]  cycle_idx,
  output micro_step_t step,
  output logic [1:0]  num_cycles
);

  // Opcode fetch from PC into IR, closes every instruction
  localparam micro_step_t FETCH = '{addr_src: ADDR_PC, bus_op: BUS_READ, load_dst: REG_IR,
                                    store_src: REG_NONE, alu_op: ALU_NOP, alu_dst: REG_NONE,
                                    idu_op: IDU_INC, halt: 1'b0};

  // Immediate byte, same shape as a fetch but lands in dst
  function automatic micro_step_t imm_read(reg_sel_t dst);
    micro_step_t s;
    s = FETCH;
    s.load_dst = dst;
    return s;
  endfunction

  function automatic micro_step_t hl_access(bus_op_t op, reg_sel_t r, idu_op_t idu);
    micro_step_t s;
    s = '{addr_src: ADDR_HL, bus_op: op, load_dst: REG_NONE, store_src: REG_NONE,
          alu_op: ALU_NOP, alu_dst: REG_NONE, idu_op: idu, halt: 1'b0};
    if (op == BUS_READ)
      s.load_dst = r;
    else if (op == BUS_WRITE)
      s.store_src = r;
    return s;
  endfunction

  // ALU work rides along with the fetch
  function automatic micro_step_t alu_fetch(alu_op_t op);
    micro_step_t s;
    s = FETCH;
    s.alu_op = op;
    s.alu_dst = REG_A;
    return s;
  endfunction

  always_comb begin
    step = FETCH;
    num_cycles = 2'd1;
    case (opcode)
      OP_LD_A_N: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = imm_read(REG_A);
      end
      OP_LD_B_N: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = imm_read(REG_B);
      end
      OP_LD_H_N: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = imm_read(REG_H);
      end
      OP_LD_L_N: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = imm_read(REG_L);
      end
      OP_LD_HL_NN: begin
        num_cycles = 2'd3;
        if (cycle_idx == 2'd0)
          step = imm_read(REG_L);  // Low byte first
        else if (cycle_idx == 2'd1)
          step = imm_read(REG_H);
      end
      OP_LD_HL_A: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = hl_access(BUS_WRITE, REG_A, IDU_NONE);
      end
      OP_LD_HLI_A: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = hl_access(BUS_WRITE, REG_A, IDU_INC);
      end
      OP_LD_A_HL: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = hl_access(BUS_READ, REG_A, IDU_NONE);
      end
      OP_INC_HL: begin
        num_cycles = 2'd2;
        if (cycle_idx == 2'd0) step = hl_access(BUS_NONE, REG_NONE, IDU_INC);  // IDU only
      end
      OP_INC_A:   step = alu_fetch(ALU_INC);
      OP_ADD_A_B: step = alu_fetch(ALU_ADD);
      OP_SUB_A_B: step = alu_fetch(ALU_SUB);
      OP_AND_A_B: step = alu_fetch(ALU_AND);
      OP_OR_A_B:  step = alu_fetch(ALU_OR);
      OP_XOR_A_B: step = alu_fetch(ALU_XOR);
      OP_HALT:    step.halt = 1'b1;
      default: ;  // NOP and anything unknown
    endcase
  end

endmodule

// File: hdl/alu.sv
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
  micro_if.exec    mif,
  input cpu_regs_t regs
);

  logic [7:0] result;

  // All arithmetic wraps at 8 bits, no flags kept
  always_comb begin
    unique case (mif.step.alu_op)
      ALU_PASS: result = regs.b;
      ALU_ADD:  result = regs.a + regs.b;
      ALU_SUB:  result = regs.a - regs.b;
      ALU_AND:  result = regs.a & regs.b;
      ALU_OR:   result = regs.a | regs.b;
      ALU_XOR:  result = regs.a ^ regs.b;
      ALU_INC:  result = regs.a + 8'd1;
      default:  result = regs.a;  // NOP holds A
    endcase
  end

  assign mif.alu_result = result;

endmodule

// File: hdl/addr_unit.sv
`timescale 1ns/10ps

module addr_unit import cpu_pkg::*; (
  micro_if.exec       mif,
  input  cpu_regs_t   regs,
  output logic [15:0] addr
);

  logic [15:0] pair;

  always_comb begin
    unique case (mif.step.addr_src)
      ADDR_PC: pair = regs.pc;
      ADDR_SP: pair = regs.sp;
      ADDR_HL: pair = {regs.h, regs.l};
      default: pair = 16'h0000;
    endcase
  end

  assign addr = pair;

  // Increment carries across the whole pair, so L=FF rolls into H
  assign mif.next_pair = (mif.step.idu_op == IDU_INC) ? pair + 16'd1 : pair;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module reg_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  micro_if.wb       mif,
  output cpu_regs_t regs
);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs.a  <= 8'h00;
      regs.b  <= 8'h00;
      regs.h  <= 8'h00;
      regs.l  <= 8'h00;
      regs.ir <= 8'h00;
      regs.pc <= `RESET_PC;
      regs.sp <= `RESET_SP;
    end else begin
      if (mif.load_en) begin  // Byte from the bus in T3
        case (mif.step.load_dst)
          REG_A:   regs.a  <= mif.load_byte;
          REG_B:   regs.b  <= mif.load_byte;
          REG_H:   regs.h  <= mif.load_byte;
          REG_L:   regs.l  <= mif.load_byte;
          REG_IR:  regs.ir <= mif.load_byte;
          default: ;
        endcase
      end
      if (mif.commit) begin
        // Pair write-back first
        case (mif.step.addr_src)
          ADDR_PC: regs.pc <= mif.next_pair;
          ADDR_SP: regs.sp <= mif.next_pair;
          ADDR_HL: {regs.h, regs.l} <= mif.next_pair;
          default: ;
        endcase
        // ALU result wins on an overlap
        case (mif.step.alu_dst)
          REG_A:   regs.a <= mif.alu_result;
          REG_B:   regs.b <= mif.alu_result;
          REG_H:   regs.h <= mif.alu_result;
          REG_L:   regs.l <= mif.alu_result;
          default: ;
        endcase
      end
    end
  end

  // Loads land in T3 and commits in T4, the sequencer keeps them apart
  a_load_commit: assert property (@(posedge clk) disable iff (reset)
    !(mif.load_en && mif.commit));

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_core import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  output logic [15:0] addr_bus,
  inout  logic [7:0]  data_bus,
  output logic        req_read,
  output logic        req_write,
  output logic        halted
);

  micro_if mif ();

  cpu_regs_t   regs;
  micro_step_t step;
  opcode_t     cur_op;      // Opcode latch, indexes the ROM
  t_phase_t    phase;
  logic [1:0]  cycle_idx;
  logic [1:0]  num_cycles;
  logic [15:0] pair_addr;
  logic [7:0]  wdata;
  logic        last_cycle;

  control_rom i_control_rom (
    .opcode     (cur_op),
    .cycle_idx  (cycle_idx),
    .step       (step),
    .num_cycles (num_cycles)
  );

  alu i_alu (.mif(mif.exec), .regs(regs));

  addr_unit i_addr_unit (.mif(mif.exec), .regs(regs), .addr(pair_addr));

  reg_file i_reg_file (.clk(clk), .reset(reset), .mif(mif.wb), .regs(regs));

  assign mif.step      = step;
  assign mif.load_en   = (phase == T3) && req_read;  // Memory answers within T3
  assign mif.load_byte = data_bus;
  assign mif.commit    = (phase == T4) && !halted;

  assign data_bus = req_write ? wdata : 'z;  // Released unless writing

  // Never run past the longest instruction
  assign last_cycle = (cycle_idx == num_cycles - 2'd1) ||
                      (cycle_idx == 2'(`MAX_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= T1;
      cycle_idx <= 2'd0;
      cur_op    <= OP_NOP;  // First cycle fetches from RESET_PC
      req_read  <= 1'b0;
      req_write <= 1'b0;
      halted    <= 1'b0;
    end else if (!halted) begin
      unique case (phase)
        T1: phase <= T2;
        T2: begin
          req_read  <= (step.bus_op == BUS_READ);
          req_write <= (step.bus_op == BUS_WRITE);
          phase     <= T3;
        end
        T3: begin
          // Requests drop as T4 begins
          req_read  <= 1'b0;
          req_write <= 1'b0;
          phase     <= T4;
        end
        T4: begin
          if (step.halt) halted <= 1'b1;
          if (last_cycle) begin
            cycle_idx <= 2'd0;
            cur_op    <= opcode_t'(regs.ir);  // IR was loaded by this cycle's fetch
          end else begin
            cycle_idx <= cycle_idx + 2'd1;
          end
          phase <= T1;
        end
      endcase
    end
  end

  // Address and write data
  always_ff @(posedge clk) begin
    if (phase == T1) addr_bus <= pair_addr;
    if (phase == T2) begin
      case (step.store_src)
        REG_A:   wdata <= regs.a;
        REG_B:   wdata <= regs.b;
        REG_H:   wdata <= regs.h;
        REG_L:   wdata <= regs.l;
        REG_IR:  wdata <= regs.ir;
        default: wdata <= 8'h00;
      endcase
    end
  end

  a_req_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_read && req_write));

  // Only the memory drives a read. A fight with the core shows up as X
  a_read_bus: assert property (@(posedge clk) disable iff (reset)
    req_read |-> !$isunknown(data_bus));

endmodule

// File: hdl/mmu.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module mmu (
  input logic        clk,
  input logic [15:0] addr_bus,
  inout logic [7:0]  data_bus,
  input logic        req_read,
  input logic        req_write,
  input logic        load_en,
  input logic [15:0] load_addr,
  input logic [7:0]  load_data
);

  localparam int AW = $clog2(`MEM_DEPTH);

  logic [7:0] mem [`MEM_DEPTH];

  // Loader has the port while the core is held in reset
  always_ff @(posedge clk) begin
    if (load_en)
      mem[load_addr[AW-1:0]] <= load_data;
    else if (req_write)
      mem[addr_bus[AW-1:0]] <= data_bus;
  end

  assign data_bus = req_read ? mem[addr_bus[AW-1:0]] : 'z;  // Combinational read

  a_load_vs_write: assert property (@(posedge clk) !(load_en && req_write));

endmodule

// File: hdl/gb_system.sv
`timescale 1ns/10ps

module gb_system (
  input  logic        clk,
  input  logic        reset,
  input  logic        load_en,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data,
  output logic        mem_write,
  output logic [15:0] mem_addr,
  output logic [7:0]  mem_wdata,
  output logic        halted
);

  logic [15:0] addr_bus;
  wire  [7:0]  data_bus;  // Shared, tri-state
  logic        req_read;
  logic        req_write;

  cpu_core i_cpu_core (
    .clk       (clk),
    .reset     (reset),
    .addr_bus  (addr_bus),
    .data_bus  (data_bus),
    .req_read  (req_read),
    .req_write (req_write),
    .halted    (halted)
  );

  mmu i_mmu (
    .clk       (clk),
    .addr_bus  (addr_bus),
    .data_bus  (data_bus),
    .req_read  (req_read),
    .req_write (req_write),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  // Store snoop
  assign mem_write = req_write;
  assign mem_addr  = addr_bus;
  assign mem_wdata = data_bus;

endmodule

// File: tests/tb_gb_system.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module tb_gb_system;

  localparam int NUM_TESTS = 10;
  localparam int TIMEOUT   = 400;  // Clocks allowed for each wait
  localparam int WATCH     = 64;   // Clocks watched after HALT

  logic        clk;
  logic        reset;
  logic        load_en;
  logic [15:0] load_addr;
  logic [7:0]  load_data;
  logic        mem_write;
  logic [15:0] mem_addr;
  logic [7:0]  mem_wdata;
  logic        halted;

  // Stimulus and expected stores, one row per test
  string       test_name [NUM_TESTS];
  logic [7:0]  prog      [NUM_TESTS][$];
  logic [15:0] exp_addr  [NUM_TESTS][$];
  logic [7:0]  exp_data  [NUM_TESTS][$];
  int          n_tests   = 0;
  int          err_count = 0;
  logic [31:0] seed      = 32'hcd3;

  gb_system i_gb_system (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .halted    (halted)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [7:0] rand_byte();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[23:16];
  endfunction

  // Modulo-256 results of the A,B operations
  function automatic logic [7:0] alu_expect(logic [7:0] op, logic [7:0] a, logic [7:0] b);
    case (op)
      8'h80:   return a + b;
      8'h90:   return a - b;
      8'hA0:   return a & b;
      8'hB0:   return a | b;
      default: return a ^ b;  // A8
    endcase
  endfunction

  function automatic logic [7:0] fill_byte(logic [15:0] addr);
    return addr[7:0] ^ {4{addr[9:8]}} ^ {2'b00, addr[15:10]} ^ 8'hA5;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    err_count++;
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic new_test(string name, logic [7:0] code[$]);
    test_name[n_tests] = name;
    prog[n_tests] = code;
    n_tests++;
  endtask

  task automatic expect_store(logic [15:0] addr, logic [7:0] data);
    exp_addr[n_tests-1].push_back(addr);
    exp_data[n_tests-1].push_back(data);
  endtask

  task automatic build_table();
    logic [7:0] code [$];
    logic [7:0] ops [5];
    string      alu_names [5];
    logic [7:0] a;
    logic [7:0] b;
    ops = '{8'h80, 8'h90, 8'hA0, 8'hB0, 8'hA8};
    alu_names = '{"alu_add", "alu_sub", "alu_and", "alu_or", "alu_xor"};
    a = rand_byte();
    code = '{8'h00, 8'h3E, a, 8'h21, 8'h00, 8'h03, 8'h77, 8'h76};
    new_test("store_imm", code);
    expect_store(16'h0300, a);
    // Store after HALT must never run
    a = rand_byte();
    code = '{8'h3E, a, 8'h21, 8'h40, 8'h03, 8'h77, 8'h76, 8'h77, 8'h76};
    new_test("halt_freeze", code);
    expect_store(16'h0340, a);
    for (int i = 0; i < 5; i++) begin
      a = rand_byte();
      b = rand_byte();
      code = '{8'h3E, a, 8'h06, b, 8'h21, 8'h10, 8'h03, ops[i], 8'h77, 8'h76};
      new_test(alu_names[i], code);
      expect_store(16'h0310, alu_expect(ops[i], a, b));
    end
    a = rand_byte();
    code = '{8'h21, 8'h07, 8'h00, 8'h7E, 8'h3C, 8'h77, 8'h76, a};  // Data byte at 0007
    new_test("read_back", code);
    expect_store(16'h0007, a + 8'd1);
    code = '{8'h21, 8'h07, 8'h00, 8'h7E, 8'h3C, 8'h77, 8'h76, 8'hFF};
    new_test("read_back_wrap", code);
    expect_store(16'h0007, 8'h00);
    // L starts at FF so the first increment carries into H
    a = rand_byte();
    code = '{8'h3E, a, 8'h26, 8'h01, 8'h2E, 8'hFF, 8'h22, 8'h22, 8'h23, 8'h77, 8'h76};
    new_test("hl_increment", code);
    expect_store(16'h01FF, a);
    expect_store(16'h0200, a);
    expect_store(16'h0202, a);
  endtask

  task automatic fill_memory();
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= 16'(i);
      load_data <= fill_byte(16'(i));
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic load_program(int t);
    for (int i = 0; i < prog[t].size(); i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= 16'(i);
      load_data <= prog[t][i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic wait_store(int t, int k);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!mem_write && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (mem_write) else
      stop_on_error($sformatf("%s: store %0d did not appear within %0d clocks",
                              test_name[t], k, TIMEOUT));
    assert (mem_addr === exp_addr[t][k]) else
      stop_on_error($sformatf("FAIL %s store %0d address: expected %h, actual %h",
                              test_name[t], k, exp_addr[t][k], mem_addr));
    assert (mem_wdata === exp_data[t][k]) else
      stop_on_error($sformatf("FAIL %s store %0d data: expected %h, actual %h",
                              test_name[t], k, exp_data[t][k], mem_wdata));
  endtask

  task automatic wait_halt(int t);
    int cycles;
    cycles = 0;
    while (!halted && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      assert (!mem_write) else
        stop_on_error($sformatf("%s: unexpected store at %h before HALT",
                                test_name[t], mem_addr));
    end
    assert (halted) else
      stop_on_error($sformatf("%s: core did not halt within %0d clocks", test_name[t], TIMEOUT));
    repeat (WATCH) begin
      @(negedge clk);
      assert (halted && !mem_write) else
        stop_on_error($sformatf("%s: core left the halted state or stored after HALT",
                                test_name[t]));
    end
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = 16'h0000;
    load_data = 8'h00;
    build_table();
    for (int t = 0; t < n_tests; t++) begin
      @(posedge clk);
      reset <= 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      assert (!halted) else
        stop_on_error($sformatf("%s: halted still high during reset", test_name[t]));
      if (t == 0) fill_memory();  // No unwritten bytes are ever fetched
      load_program(t);
      @(posedge clk);
      reset <= 1'b0;
      for (int k = 0; k < exp_addr[t].size(); k++)
        wait_store(t, k);
      wait_halt(t);
    end
    if (err_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/micro_if.sv
hdl/control_rom.sv
hdl/alu.sv
hdl/addr_unit.sv
hdl/reg_file.sv
hdl/cpu_core.sv
hdl/mmu.sv
hdl/gb_system.sv
tests/tb_gb_system.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps --top-module tb_gb_system \
  -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1
